// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;  // data, address and instruction words
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [2:0] {
        reg_arith,
        imm_arith,
        load,
        store,
        branch,
        jump,
        illegal
    } op_class_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_t;

    typedef enum logic [1:0] {
        idle,
        fetch_owner,
        data_owner
    } arb_state_t;

    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;

endpackage

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
    input logic clk,
    input logic rst,
    input reg_addr_t rs1_addr,
    input reg_addr_t rs2_addr,
    input logic wr_en,
    input reg_addr_t wr_addr,
    input word_t wr_data,
    output word_t rs1_data,
    output word_t rs2_data
);
    word_t regs [1:31];  // x0 has no storage

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic redirect_valid,
    input word_t redirect_pc,
    input word_t ibus_dat_r,
    input logic ibus_ack,
    output logic done,
    output word_t pc_out,
    output word_t instr_out,
    output logic ibus_cyc,
    output logic ibus_stb,
    output word_t ibus_adr
);
    word_t next_pc;  // address of the next fetch
    logic discard;   // fetch on the bus went stale on a redirect

    assign ibus_stb = ibus_cyc;

    always_ff @(posedge clk) begin
        if (!rst) begin
            done <= 1'b0;
            ibus_cyc <= 1'b0;
            discard <= 1'b0;
            next_pc <= RESET_PC;
        end else begin
            if (done && !stall) begin
                done <= 1'b0;
            end
            if (ibus_cyc && ibus_ack) begin
                ibus_cyc <= 1'b0;
                discard <= 1'b0;
                if (!discard && !redirect_valid) begin
                    done <= 1'b1;
                    next_pc <= ibus_adr + 32'd4;
                end
            end else if (!ibus_cyc && !done && !redirect_valid) begin
                ibus_cyc <= 1'b1;  // buffer empty, prefetch
            end
            if (redirect_valid) begin
                done <= 1'b0;
                next_pc <= redirect_pc;
                if (ibus_cyc && !ibus_ack) begin
                    discard <= 1'b1;  // let it finish, drop the data
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ibus_cyc && ibus_ack) begin
            pc_out <= ibus_adr;
            instr_out <= ibus_dat_r;
        end
        if (!ibus_cyc) begin
            ibus_adr <= next_pc;  // frozen while the access is open
        end
    end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic prev_done,
    input word_t pc_in,
    input word_t instr_in,
    input word_t rs1_data,
    input word_t rs2_data,
    input logic next_stall,
    input logic retire_valid,
    output logic stall,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic done,
    output word_t pc_out,
    output op_class_t op_class,
    output alu_op_t alu_op,
    output word_t imm,
    output word_t src1,
    output word_t src2,
    output reg_addr_t rd
);
    logic busy;  // an instruction is in flight until it retires
    logic take;
    logic [2:0] funct3;
    op_class_t cls;
    alu_op_t aop;
    word_t imm_val;
    logic writes_rd;

    assign stall = busy;
    assign take = prev_done && !busy;
    assign funct3 = instr_in[14:12];
    assign rs1_addr = instr_in[19:15];
    assign rs2_addr = instr_in[24:20];
    assign writes_rd = cls inside {reg_arith, imm_arith, load, jump};

    always_comb begin
        aop = alu_add;
        case (instr_in[6:0])
            OPC_OP: begin
                cls = reg_arith;
                case (funct3)
                    3'b000: aop = instr_in[30] ? alu_sub : alu_add;
                    3'b100: aop = alu_xor;
                    3'b110: aop = alu_or;
                    3'b111: aop = alu_and;
                    default: cls = illegal;  // shifts and compares not supported
                endcase
            end
            OPC_OP_IMM: cls = (funct3 == 3'b000) ? imm_arith : illegal;
            OPC_LOAD: cls = (funct3 == 3'b010) ? load : illegal;
            OPC_STORE: cls = (funct3 == 3'b010) ? store : illegal;
            OPC_BRANCH: cls = (funct3 == 3'b000) ? branch : illegal;
            OPC_JAL: cls = jump;
            default: cls = illegal;
        endcase
    end

    always_comb begin
        case (cls)
            store: imm_val = {{20{instr_in[31]}}, instr_in[31:25], instr_in[11:7]};
            branch: imm_val = {{19{instr_in[31]}}, instr_in[31], instr_in[7],
                               instr_in[30:25], instr_in[11:8], 1'b0};
            jump: imm_val = {{11{instr_in[31]}}, instr_in[31], instr_in[19:12],
                             instr_in[20], instr_in[30:21], 1'b0};
            default: imm_val = {{20{instr_in[31]}}, instr_in[31:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (take) begin
            busy <= 1'b1;
            done <= 1'b1;
        end else begin
            if (retire_valid) begin
                busy <= 1'b0;
            end
            if (done && !next_stall) begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_out <= pc_in;
            op_class <= cls;
            alu_op <= aop;
            imm <= imm_val;
            src1 <= rs1_data;
            src2 <= rs2_data;
            rd <= writes_rd ? instr_in[11:7] : '0;  // 0 means no write
        end
    end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic prev_done,
    input word_t pc_in,
    input op_class_t op_class,
    input alu_op_t alu_op,
    input word_t imm,
    input word_t src1,
    input word_t src2,
    input reg_addr_t rd,
    input logic next_stall,
    output logic stall,
    output logic done,
    output word_t pc_out,
    output op_class_t op_class_out,
    output reg_addr_t rd_out,
    output word_t result,
    output word_t store_data,
    output logic redirect_valid,
    output word_t redirect_pc
);
    logic take;
    logic taken;  // jal, or beq with equal operands
    word_t alu_b;
    word_t res;

    assign stall = done && next_stall;
    assign take = prev_done && !stall;
    assign alu_b = (op_class == reg_arith) ? src2 : imm;
    assign taken = (op_class == jump) || (op_class == branch && src1 == src2);

    // loads and stores decode as add, so this also gives src1 + imm
    always_comb begin
        case (alu_op)
            alu_sub: res = src1 - alu_b;
            alu_and: res = src1 & alu_b;
            alu_or: res = src1 | alu_b;
            alu_xor: res = src1 ^ alu_b;
            default: res = src1 + alu_b;
        endcase
        if (op_class == jump) begin
            res = pc_in + 32'd4;  // link address
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            done <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= take && taken;
            if (take) begin
                done <= 1'b1;
            end else if (!next_stall) begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_out <= pc_in;
            op_class_out <= op_class;
            rd_out <= rd;
            result <= res;
            store_data <= src2;
            redirect_pc <= pc_in + imm;
        end
    end

endmodule

// ==== verilog/memory_writeback_stage.sv ====
`timescale 1ns/1ps

module memory_writeback_stage import cpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic prev_done,
    input word_t pc_in,
    input op_class_t op_class,
    input reg_addr_t rd,
    input word_t result,
    input word_t store_data,
    input word_t dbus_dat_r,
    input logic dbus_ack,
    output logic stall,
    output logic dbus_cyc,
    output logic dbus_stb,
    output logic dbus_we,
    output word_t dbus_adr,
    output word_t dbus_dat_w,
    output logic rf_wr_en,
    output reg_addr_t rf_wr_addr,
    output word_t rf_wr_data,
    output logic retire_valid,
    output word_t retire_pc,
    output reg_addr_t retire_rd,
    output word_t retire_data
);
    logic take;
    logic is_mem;
    logic mem_done;

    assign stall = dbus_cyc;  // busy only while a data access is open
    assign take = prev_done && !stall;
    assign is_mem = (op_class == load) || (op_class == store);
    assign mem_done = dbus_cyc && dbus_ack;
    assign dbus_stb = dbus_cyc;
    assign rf_wr_addr = retire_rd;
    assign rf_wr_data = retire_data;

    always_ff @(posedge clk) begin
        if (!rst) begin
            dbus_cyc <= 1'b0;
            retire_valid <= 1'b0;
            rf_wr_en <= 1'b0;
        end else begin
            retire_valid <= 1'b0;
            rf_wr_en <= 1'b0;
            if (take && is_mem) begin
                dbus_cyc <= 1'b1;
            end else if (take) begin
                retire_valid <= 1'b1;
                rf_wr_en <= (rd != '0);
            end else if (mem_done) begin
                dbus_cyc <= 1'b0;
                retire_valid <= 1'b1;
                rf_wr_en <= (retire_rd != '0);  // stores carry rd 0
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            retire_pc <= pc_in;
            retire_rd <= rd;
            retire_data <= result;
            dbus_we <= (op_class == store);
            dbus_adr <= result;
            dbus_dat_w <= store_data;
        end else if (mem_done && !dbus_we) begin
            retire_data <= dbus_dat_r;
        end
    end

endmodule

// ==== verilog/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import cpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic ibus_cyc,
    input logic ibus_stb,
    input word_t ibus_adr,
    input logic dbus_cyc,
    input logic dbus_stb,
    input logic dbus_we,
    input word_t dbus_adr,
    input word_t dbus_dat_w,
    input word_t wb_dat_r,
    input logic wb_ack,
    output word_t ibus_dat_r,
    output logic ibus_ack,
    output word_t dbus_dat_r,
    output logic dbus_ack,
    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we,
    output word_t wb_adr,
    output word_t wb_dat_w
);
    arb_state_t state;

    assign ibus_dat_r = wb_dat_r;
    assign dbus_dat_r = wb_dat_r;
    assign wb_dat_w = dbus_dat_w;  // only the data master writes

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (dbus_cyc && dbus_stb) begin
                        state <= data_owner;  // data wins a tie
                    end else if (ibus_cyc && ibus_stb) begin
                        state <= fetch_owner;
                    end
                end
                fetch_owner, data_owner: begin
                    if (wb_ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_comb begin
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = ibus_adr;
        ibus_ack = 1'b0;
        dbus_ack = 1'b0;
        case (state)
            fetch_owner: begin
                wb_cyc = ibus_cyc;
                wb_stb = ibus_stb;
                ibus_ack = wb_ack;
            end
            data_owner: begin
                wb_cyc = dbus_cyc;
                wb_stb = dbus_stb;
                wb_we = dbus_we;
                wb_adr = dbus_adr;
                dbus_ack = wb_ack;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input logic clk,
    input logic rst,
    input word_t wb_dat_r,
    input logic wb_ack,
    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we,
    output word_t wb_adr,
    output word_t wb_dat_w,
    output logic retire_valid,
    output word_t retire_pc,
    output reg_addr_t retire_rd,
    output word_t retire_data
);
    logic f_done;
    word_t f_pc;
    word_t f_instr;
    logic ibus_cyc;
    logic ibus_stb;
    word_t ibus_adr;
    word_t ibus_dat_r;
    logic ibus_ack;

    logic d_stall;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;
    logic d_done;
    word_t d_pc;
    op_class_t d_op_class;
    alu_op_t d_alu_op;
    word_t d_imm;
    word_t d_src1;
    word_t d_src2;
    reg_addr_t d_rd;

    logic e_stall;
    logic e_done;
    word_t e_pc;
    op_class_t e_op_class;
    reg_addr_t e_rd;
    word_t e_result;
    word_t e_store_data;
    logic redirect_valid;
    word_t redirect_pc;

    logic m_stall;
    logic dbus_cyc;
    logic dbus_stb;
    logic dbus_we;
    word_t dbus_adr;
    word_t dbus_dat_w;
    word_t dbus_dat_r;
    logic dbus_ack;
    logic rf_wr_en;
    reg_addr_t rf_wr_addr;
    word_t rf_wr_data;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch_stage (
        .clk            (clk),
        .rst            (rst),
        .stall          (d_stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .ibus_dat_r     (ibus_dat_r),
        .ibus_ack       (ibus_ack),
        .done           (f_done),
        .pc_out         (f_pc),
        .instr_out      (f_instr),
        .ibus_cyc       (ibus_cyc),
        .ibus_stb       (ibus_stb),
        .ibus_adr       (ibus_adr)
    );

    decode_stage u_decode_stage (
        .clk          (clk),
        .rst          (rst),
        .prev_done    (f_done),
        .pc_in        (f_pc),
        .instr_in     (f_instr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .next_stall   (e_stall),
        .retire_valid (retire_valid),
        .stall        (d_stall),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .done         (d_done),
        .pc_out       (d_pc),
        .op_class     (d_op_class),
        .alu_op       (d_alu_op),
        .imm          (d_imm),
        .src1         (d_src1),
        .src2         (d_src2),
        .rd           (d_rd)
    );

    register_file u_register_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wr_en    (rf_wr_en),
        .wr_addr  (rf_wr_addr),
        .wr_data  (rf_wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_stage u_execute_stage (
        .clk            (clk),
        .rst            (rst),
        .prev_done      (d_done),
        .pc_in          (d_pc),
        .op_class       (d_op_class),
        .alu_op         (d_alu_op),
        .imm            (d_imm),
        .src1           (d_src1),
        .src2           (d_src2),
        .rd             (d_rd),
        .next_stall     (m_stall),
        .stall          (e_stall),
        .done           (e_done),
        .pc_out         (e_pc),
        .op_class_out   (e_op_class),
        .rd_out         (e_rd),
        .result         (e_result),
        .store_data     (e_store_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    memory_writeback_stage u_memory_writeback_stage (
        .clk          (clk),
        .rst          (rst),
        .prev_done    (e_done),
        .pc_in        (e_pc),
        .op_class     (e_op_class),
        .rd           (e_rd),
        .result       (e_result),
        .store_data   (e_store_data),
        .dbus_dat_r   (dbus_dat_r),
        .dbus_ack     (dbus_ack),
        .stall        (m_stall),
        .dbus_cyc     (dbus_cyc),
        .dbus_stb     (dbus_stb),
        .dbus_we      (dbus_we),
        .dbus_adr     (dbus_adr),
        .dbus_dat_w   (dbus_dat_w),
        .rf_wr_en     (rf_wr_en),
        .rf_wr_addr   (rf_wr_addr),
        .rf_wr_data   (rf_wr_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    bus_arbiter u_bus_arbiter (
        .clk        (clk),
        .rst        (rst),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_adr   (ibus_adr),
        .dbus_cyc   (dbus_cyc),
        .dbus_stb   (dbus_stb),
        .dbus_we    (dbus_we),
        .dbus_adr   (dbus_adr),
        .dbus_dat_w (dbus_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .ibus_dat_r (ibus_dat_r),
        .ibus_ack   (ibus_ack),
        .dbus_dat_r (dbus_dat_r),
        .dbus_ack   (dbus_ack),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w)
    );

endmodule

// ==== sim/cpu_asserts.sv ====
`timescale 1ns/1ps

module cpu_asserts import cpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic wb_ack,
    input word_t wb_adr,
    input word_t wb_dat_w,
    input logic retire_valid,
    input arb_state_t arb_state
);

    // a master keeps cyc and stb up until its ack
    request_until_ack: assert property (@(posedge clk) disable iff (!rst)
        wb_stb && !wb_ack |=> wb_cyc && wb_stb)
        else $error("wb_cyc or wb_stb dropped before ack");

    // write data only matters on a write
    request_held: assert property (@(posedge clk) disable iff (!rst)
        wb_stb && !wb_ack |=> $stable(wb_adr) && (!wb_we || $stable(wb_dat_w)))
        else $error("bus address or write data changed before ack");

    single_retire: assert property (@(posedge clk) disable iff (!rst)
        retire_valid |=> !retire_valid)
        else $error("retire_valid stayed high for two cycles");

    // the grant lasts until the owner's ack
    ack_in_grant: assert property (@(posedge clk) disable iff (!rst)
        wb_ack |-> arb_state != idle)
        else $error("wb_ack came while the bus arbiter had no owner");

endmodule

bind cpu_top cpu_asserts u_cpu_asserts (
    .clk          (clk),
    .rst          (rst),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_ack       (wb_ack),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .retire_valid (retire_valid),
    .arb_state    (u_bus_arbiter.state)
);

// ==== sim/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_WAIT = 3;          // wait states per bus access
    localparam int CYCLES_PER_ROW = 40;   // a fetch and a load, both at MAX_WAIT, plus slack
    localparam word_t DATA_ADDR = 32'h100;

    logic clk;
    logic rst;
    word_t wb_dat_r = '0;
    logic wb_ack = 1'b0;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    word_t wb_adr;
    word_t wb_dat_w;
    logic retire_valid;
    word_t retire_pc;
    reg_addr_t retire_rd;
    word_t retire_data;

    word_t prog [$];        // instruction words, pc = 4 * index
    string exp_name [$];    // one row per expected retirement
    word_t exp_pc [$];
    reg_addr_t exp_rd [$];
    word_t exp_data [$];
    word_t stored_value;

    word_t mem [0:255];
    int seed = 65688;
    int wait_left;
    logic in_access;
    int row = 0;
    int mismatches = 0;
    int mem_errors = 0;
    int timed_out = 0;
    int cycles = 0;

    cpu_top #(
        .RESET_PC (32'h0)
    ) u_cpu_top (
        .clk          (clk),
        .rst          (rst),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic word_t i_type(int imm, int rs1, int f3, int rd, logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic word_t s_type(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(int imm, int rs2, int rs1);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t j_type(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic word_t next_pc();
        return word_t'(prog.size() * 4);
    endfunction

    function automatic word_t fill_word(word_t addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    task automatic add_step(string name, word_t instr, int rd, word_t data, bit skipped);
        word_t pc;
        pc = next_pc();
        prog.push_back(instr);
        if (!skipped) begin
            exp_name.push_back(name);
            exp_pc.push_back(pc);
            exp_rd.push_back(reg_addr_t'(rd));
            exp_data.push_back(data);
        end
    endtask

    task automatic build_program();
        stored_value = 5 + 7;  // x3 at the time of the store
        add_step("addi x1", i_type(5, 0, 0, 1, OPC_OP_IMM), 1, 5, 1'b0);
        add_step("addi x2", i_type(7, 0, 0, 2, OPC_OP_IMM), 2, 7, 1'b0);
        add_step("add", r_type(0, 2, 1, 0, 3), 3, 5 + 7, 1'b0);
        add_step("sub", r_type(32, 2, 1, 0, 4), 4, 5 - 7, 1'b0);
        add_step("and", r_type(0, 2, 1, 7, 5), 5, 5 & 7, 1'b0);
        add_step("or", r_type(0, 2, 1, 6, 6), 6, 5 | 7, 1'b0);
        add_step("xor", r_type(0, 2, 1, 4, 7), 7, 5 ^ 7, 1'b0);
        add_step("sw", s_type(DATA_ADDR, 3, 0), 0, 0, 1'b0);
        add_step("lw", i_type(DATA_ADDR, 0, 2, 5, OPC_LOAD), 5, stored_value, 1'b0);
        add_step("beq taken", b_type(8, 1, 1), 0, 0, 1'b0);
        add_step("after beq", i_type(1, 0, 0, 9, OPC_OP_IMM), 0, 0, 1'b1);
        add_step("beq not taken", b_type(8, 2, 1), 0, 0, 1'b0);
        add_step("fall-through", i_type(3, 0, 0, 10, OPC_OP_IMM), 10, 3, 1'b0);
        add_step("jal", j_type(8, 8), 8, next_pc() + 4, 1'b0);
        add_step("after jal", i_type(1, 0, 0, 11, OPC_OP_IMM), 0, 0, 1'b1);
        add_step("illegal lui", {20'h12345, 5'd1, 7'b0110111}, 0, 0, 1'b0);
        add_step("addi x0", i_type(9, 0, 0, 0, OPC_OP_IMM), 0, 0, 1'b0);
        add_step("read x1 and x0", r_type(0, 0, 1, 0, 12), 12, 5, 1'b0);
        add_step("jal loop", j_type(0, 0), 0, 0, 1'b0);  // parks the core
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // wishbone slave, loads the program while reset is low
    always @(posedge clk) begin
        if (!rst) begin
            wb_ack <= 1'b0;
            in_access = 1'b0;
            for (int i = 0; i < 256; i++) begin
                mem[i] = (i < prog.size()) ? prog[i] : fill_word(word_t'(i * 4));
            end
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!in_access) begin
                in_access = 1'b1;
                wait_left = $unsigned($random(seed)) % (MAX_WAIT + 1);
            end
            if (wait_left == 0) begin
                in_access = 1'b0;
                wb_ack <= 1'b1;
                if (wb_we) begin
                    mem[wb_adr[9:2]] = wb_dat_w;
                end else begin
                    wb_dat_r <= mem[wb_adr[9:2]];
                end
            end else begin
                wait_left--;
            end
        end
    end

    // retirements must follow the table in order
    always @(posedge clk) begin
        if (rst && retire_valid && row < exp_pc.size()) begin
            assert (retire_pc == exp_pc[row]) else begin
                mismatches++;
                $display("Error %s: pc expected %h, actual %h",
                         exp_name[row], exp_pc[row], retire_pc);
            end
            assert (retire_rd == exp_rd[row]) else begin
                mismatches++;
                $display("Error %s: rd expected %0d, actual %0d",
                         exp_name[row], exp_rd[row], retire_rd);
            end
            if (exp_rd[row] != '0) begin
                assert (retire_data == exp_data[row]) else begin
                    mismatches++;
                    $display("Error %s: data expected %h, actual %h",
                             exp_name[row], exp_data[row], retire_data);
                end
            end
            row++;
        end
    end

    initial begin
        int limit;
        rst = 1'b0;
        build_program();
        limit = exp_pc.size() * CYCLES_PER_ROW;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        while (row < exp_pc.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (row < exp_pc.size()) begin
            timed_out = 1;
            $display("Timeout: only %0d of %0d instructions retired within %0d cycles",
                     row, exp_pc.size(), limit);
        end
        assert (mem[DATA_ADDR[9:2]] == stored_value) else begin
            mem_errors++;
            $display("Error memory at %h: expected %h, actual %h",
                     DATA_ADDR, stored_value, mem[DATA_ADDR[9:2]]);
        end
        $display("Retire mismatches: %0d, memory mismatches: %0d, timeouts: %0d",
                 mismatches, mem_errors, timed_out);
        if (mismatches == 0 && mem_errors == 0 && timed_out == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/cpu_pkg.sv
verilog/register_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_writeback_stage.sv
verilog/bus_arbiter.sv
verilog/cpu_top.sv
sim/cpu_asserts.sv
sim/tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f sources.f -o tb_cpu \
    && ./obj_dir/tb_cpu 2>&1 | tee sim.log \
    && grep -q "Test completed successfully" sim.log \
    || { echo "simulation did not pass"; exit 1; }
